/* tb/add_two_number_assertions.sv */
// Bound checker that shadows the adder operands and asserts on every response
`timescale 1ns/1ps
`default_nettype none

module add_two_number_assertions (
  input logic                  clk_i,
  input logic                  rst_n,
  input add_bus_pkg::reg_req_t req,
  input add_bus_pkg::reg_rsp_t rsp
);

  import add_regs_pkg::*;
  import add_bus_pkg::*;

  // Number of failed response checks
  int unsigned fail_count = 0;

  reg_req_t           prev_req;
  data_word_t         shadow_a;
  data_word_t         shadow_b;
  logic [63:0]        total_u;
  logic signed [63:0] total_s;
  logic               exp_carry;
  logic               exp_ovf;
  logic               exp_error;
  data_word_t         exp_rdata;

  // ------------------------------------------------
  // Shadow of the operands and the last request
  // ------------------------------------------------

  // Only exact OP_A and OP_B addresses count as legal writes
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      prev_req <= '0;
      shadow_a <= '0;
      shadow_b <= '0;
    end else begin
      prev_req <= req;
      if (req.valid && req.write && (req.addr == OFF_OP_A)) begin
        shadow_a <= req.wdata;
      end
      if (req.valid && req.write && (req.addr == OFF_OP_B)) begin
        shadow_b <= req.wdata;
      end
    end
  end

  // Carry and overflow from wide arithmetic
  assign total_u   = {32'b0, shadow_a} + {32'b0, shadow_b};
  assign total_s   = $signed({{32{shadow_a[31]}}, shadow_a})
                   + $signed({{32{shadow_b[31]}}, shadow_b});
  assign exp_carry = (total_u > 64'h0000_0000_FFFF_FFFF);
  assign exp_ovf   = (total_s > 64'sd2147483647) || (total_s < -64'sd2147483648);

  // Expected response for the request of the cycle before
  always_comb begin
    if (prev_req.write) begin
      exp_error = (prev_req.addr != OFF_OP_A) && (prev_req.addr != OFF_OP_B);
    end else begin
      // Reads are legal at the eight word addresses of the span
      exp_error = !(prev_req.addr inside {OFF_OP_A, OFF_OP_B, OFF_SUM, OFF_STATUS,
                                          OFF_ID, 32'h14, 32'h18, 32'h1C});
    end
    exp_rdata = '0;
    if (!prev_req.write && !exp_error) begin
      case (prev_req.addr)
        OFF_OP_A:   exp_rdata = shadow_a;
        OFF_OP_B:   exp_rdata = shadow_b;
        OFF_SUM:    exp_rdata = total_u[31:0];
        OFF_STATUS: begin
          exp_rdata[ST_CARRY_BIT] = exp_carry;
          exp_rdata[ST_OVF_BIT]   = exp_ovf;
        end
        OFF_ID:     exp_rdata = PERIPH_ID;
        default:    exp_rdata = '0;
      endcase
    end
  end

  // ------------------------------------------------
  // Response checks
  // ------------------------------------------------

  // One pulse for each request and none without one
  a_rsp_valid: assert property (@(posedge clk_i) disable iff (!rst_n)
    rsp.valid == prev_req.valid)
    else begin
      $error("[FAIL] rsp_valid expected %0b actual %0b",
             $sampled(prev_req.valid), $sampled(rsp.valid));
      fail_count++;
    end

  a_rsp_error: assert property (@(posedge clk_i) disable iff (!rst_n)
    prev_req.valid |-> (rsp.error == exp_error))
    else begin
      $error("[FAIL] rsp_error addr %h expected %0b actual %0b",
             $sampled(prev_req.addr), $sampled(exp_error), $sampled(rsp.error));
      fail_count++;
    end

  a_rsp_rdata: assert property (@(posedge clk_i) disable iff (!rst_n)
    prev_req.valid |-> (rsp.rdata == exp_rdata))
    else begin
      $error("[FAIL] rsp_rdata addr %h expected %h actual %h",
             $sampled(prev_req.addr), $sampled(exp_rdata), $sampled(rsp.rdata));
      fail_count++;
    end

  // Quiet bus between responses
  a_idle_clean: assert property (@(posedge clk_i) disable iff (!rst_n)
    !prev_req.valid |-> (!rsp.error && (rsp.rdata == '0)))
    else begin
      $error("[FAIL] idle_rsp expected error 0 data 0 actual error %0b data %h",
             $sampled(rsp.error), $sampled(rsp.rdata));
      fail_count++;
    end

endmodule

bind add_two_number_wrapper add_two_number_assertions u_assertions (
  .clk_i (clk_i),
  .rst_n (rst_n),
  .req   (req),
  .rsp   (rsp)
);

`default_nettype wire

/* tb/tb_add_two_number.sv */
// Testbench for the adder peripheral: directed, random and mixed register traffic
`timescale 1ns/1ps
`default_nettype none

module tb_add_two_number;

  import add_regs_pkg::*;
  import add_bus_pkg::*;

  // ------------------------------------------------
  // Run length and limits
  // ------------------------------------------------

  localparam int RESET_CYCLES    = 4;
  localparam int RAND_PAIRS      = 100;
  localparam int MIXED_REQS      = 48;
  // Upper bound of the directed part, gaps included
  localparam int DIRECTED_CYCLES = 60;
  // Four requests per random pair, a few idle cycles at the end
  localparam int STIM_CYCLES     = RESET_CYCLES + DIRECTED_CYCLES
                                 + 4 * RAND_PAIRS + MIXED_REQS + 8;
  localparam int TIMEOUT_CYCLES  = STIM_CYCLES + STIM_CYCLES / 2;

  logic     clk;
  logic     rst_n;
  reg_req_t req;
  reg_rsp_t rsp;

  int unsigned cycle_count;
  int unsigned req_count;
  int unsigned timeouts;

  // Legal, empty, misaligned and out-of-span addresses for the mixed phase
  reg_addr_t mixed_addrs [11] = '{
    32'h00, 32'h04, 32'h08, 32'h0C, 32'h10, 32'h14,
    32'h18, 32'h1C, 32'h20, 32'h02, 32'h41
  };

  add_two_number_wrapper u_add_two_number_wrapper (
    .clk_i (clk),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp)
  );

  // 20 ns clock
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ------------------------------------------------
  // Request tasks
  // ------------------------------------------------

  // One request, held for exactly one cycle
  task automatic send_request(input logic write, input reg_addr_t addr,
                              input data_word_t wdata);
    @(posedge clk);
    #2;
    req.valid = 1'b1;
    req.write = write;
    req.addr  = addr;
    req.wdata = wdata;
    req_count++;
  endtask

  task automatic write_word(input reg_addr_t addr, input data_word_t wdata);
    send_request(1'b1, addr, wdata);
  endtask

  // Garbage on wdata, which reads must ignore
  task automatic read_word(input reg_addr_t addr);
    send_request(1'b0, addr, 32'hDEAD_BEEF);
  endtask

  task automatic go_idle(input int cycles);
    @(posedge clk);
    #2;
    req = '0;
    repeat (cycles - 1) @(posedge clk);
  endtask

  // Load both operands, then read the sum and the flags back to back
  task automatic add_and_check(input data_word_t a, input data_word_t b);
    write_word(OFF_OP_A, a);
    write_word(OFF_OP_B, b);
    read_word(OFF_SUM);
    read_word(OFF_STATUS);
  endtask

  task automatic print_summary();
    $display("Summary: %0d requests, %0d cycles, %0d assertion failures, %0d timeouts",
             req_count, cycle_count, u_add_two_number_wrapper.u_assertions.fail_count,
             timeouts);
  endtask

  // ------------------------------------------------
  // Watchdog
  // ------------------------------------------------

  initial begin
    cycle_count = 0;
    timeouts    = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    timeouts = 1;
    $display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
    print_summary();
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------

  initial begin
    data_word_t rand_a;
    data_word_t rand_b;
    int         pick;
    req       = '0;
    rst_n     = 1'b0;
    req_count = 0;
    void'($urandom(32'h7aa2));
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Quiet bus right after reset
    go_idle(3);

    // Readback, also in the cycle right after the write
    write_word(OFF_OP_A, 32'h1234_5678);
    read_word(OFF_OP_A);
    write_word(OFF_OP_B, 32'hCAFE_F00D);
    read_word(OFF_OP_B);
    read_word(OFF_SUM);
    read_word(OFF_STATUS);
    go_idle(2);

    // Carry, positive overflow, negative overflow with carry
    add_and_check(32'hFFFF_FFFF, 32'h0000_0001);
    add_and_check(32'h7FFF_FFFF, 32'h0000_0001);
    add_and_check(32'h8000_0000, 32'h8000_0000);
    go_idle(2);

    // ID and the empty words
    read_word(OFF_ID);
    read_word(32'h14);
    read_word(32'h18);
    read_word(32'h1C);
    go_idle(2);

    // Illegal writes, operands must stay put
    write_word(OFF_SUM, 32'h1111_1111);
    write_word(OFF_STATUS, 32'h2222_2222);
    write_word(OFF_ID, 32'h3333_3333);
    write_word(32'h14, 32'h4444_4444);
    write_word(32'h02, 32'h5555_5555);
    write_word(32'h20, 32'h6666_6666);
    write_word(32'h100, 32'h7777_7777);
    read_word(OFF_OP_A);
    read_word(OFF_OP_B);
    go_idle(2);

    // Illegal reads
    read_word(32'h01);
    read_word(32'h06);
    read_word(32'h20);
    read_word(32'h1000);
    go_idle(2);

    // Random operand pairs
    for (int i = 0; i < RAND_PAIRS; i++) begin
      rand_a = $urandom();
      rand_b = $urandom();
      add_and_check(rand_a, rand_b);
    end

    // Back-to-back mix of reads and writes
    for (int i = 0; i < MIXED_REQS; i++) begin
      pick = $urandom_range(0, 10);
      send_request(1'($urandom_range(0, 1)), mixed_addrs[pick], $urandom());
    end

    // Let the last responses through the checker
    go_idle(3);

    print_summary();
    if (u_add_two_number_wrapper.u_assertions.fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
verilog/add_regs_pkg.sv
verilog/add_bus_pkg.sv
verilog/add_operand_bank.sv
verilog/add_read_tracker.sv
verilog/add_response_unit.sv
verilog/add_two_number_wrapper.sv
tb/add_two_number_assertions.sv
tb/tb_add_two_number.sv

/* verilog/add_bus_pkg.sv */
// Register port structs and the internal path results of the adder peripheral
`default_nettype none

package add_bus_pkg;

  // ------------------------------------------------
  // Register port, as exposed by the coprocessor
  // ------------------------------------------------

  // Single-cycle request, no back-pressure
  typedef struct packed {
    // Strobe, one cycle per request
    logic                   valid;
    // High for write, low for read
    logic                   write;
    // Byte address
    add_regs_pkg::reg_addr_t  addr;
    // Write payload, ignored on reads
    add_regs_pkg::data_word_t wdata;
  } reg_req_t;

  // Response, one cycle after its request
  typedef struct packed {
    logic                     valid;
    // Unmapped, misaligned or read-only access
    logic                     error;
    // Zero on writes and on errors
    add_regs_pkg::data_word_t rdata;
  } reg_rsp_t;

  // ------------------------------------------------
  // Internal results of the two paths
  // ------------------------------------------------

  // Registered outcome of a write, from the operand bank
  typedef struct packed {
    logic done;
    logic error;
  } wr_result_t;

  // Registered read waiting for its data, from the read tracker
  typedef struct packed {
    logic                       pending;
    logic                       error;
    add_regs_pkg::word_offset_t word_offset;
  } rd_pending_t;

endpackage

`default_nettype wire

/* verilog/add_operand_bank.sv */
// Operand bank: decodes register writes and holds the two adder operands
`timescale 1ns/1ps
`default_nettype none

module add_operand_bank (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  add_bus_pkg::reg_req_t    req,
  output add_regs_pkg::data_word_t op_a,
  output add_regs_pkg::data_word_t op_b,
  output add_bus_pkg::wr_result_t  wr_res
);

  import add_regs_pkg::*;
  import add_bus_pkg::*;

  logic         wr_req;
  word_offset_t wr_offset;
  logic         wr_out_of_span;
  logic         wr_misaligned;
  logic         wr_not_writable;
  logic         wr_error;

  // ------------------------------------------------
  // Write decode
  // ------------------------------------------------

  assign wr_req    = req.valid && req.write;
  assign wr_offset = req.addr[4:2];

  // Anything at or past the span is unmapped
  assign wr_out_of_span = (req.addr >= ADDR_SPAN);
  // Only whole-word accesses are legal
  assign wr_misaligned  = (req.addr[1:0] != 2'b00);
  // SUM, STATUS, ID and the empty words 5..7 take no writes
  assign wr_not_writable = (wr_offset != WOFF_OP_A) && (wr_offset != WOFF_OP_B);

  assign wr_error = wr_out_of_span || wr_misaligned || wr_not_writable;

  // ------------------------------------------------
  // Operand registers
  // ------------------------------------------------

  // A faulty write leaves both operands as they were
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      op_a <= '0;
      op_b <= '0;
    end else if (wr_req && !wr_error) begin
      if (wr_offset == WOFF_OP_A) begin
        op_a <= req.wdata;
      end
      if (wr_offset == WOFF_OP_B) begin
        op_b <= req.wdata;
      end
    end
  end

  // Outcome of every write, seen by the response unit one cycle later
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      wr_res.done  <= 1'b0;
      wr_res.error <= 1'b0;
    end else begin
      wr_res.done  <= wr_req;
      wr_res.error <= wr_req && wr_error;
    end
  end

endmodule

`default_nettype wire

/* verilog/add_read_tracker.sv */
// Read tracker: registers each read request with its word offset and address check
`timescale 1ns/1ps
`default_nettype none

module add_read_tracker (
  input  logic                     clk_i,
  input  logic                     rst_n,
  input  add_bus_pkg::reg_req_t    req,
  output add_bus_pkg::rd_pending_t rd_pend
);

  import add_regs_pkg::*;
  import add_bus_pkg::*;

  logic rd_req;
  logic rd_error;

  // ------------------------------------------------
  // Read address check
  // ------------------------------------------------

  assign rd_req = req.valid && !req.write;

  // Out of span or not word aligned.
  // Words 5..7 inside the span are legal and read as zero
  assign rd_error = (req.addr >= ADDR_SPAN) || (req.addr[1:0] != 2'b00);

  // ------------------------------------------------
  // Pending entry, lives for one cycle
  // ------------------------------------------------

  // Control bits of the entry
  always_ff @(posedge clk_i) begin
    if (!rst_n) begin
      rd_pend.pending <= 1'b0;
      rd_pend.error   <= 1'b0;
    end else begin
      rd_pend.pending <= rd_req;
      rd_pend.error   <= rd_req && rd_error;
    end
  end

  // Offset is only looked at while pending is set
  always_ff @(posedge clk_i) begin
    if (rd_req) begin
      rd_pend.word_offset <= req.addr[4:2];
    end
  end

endmodule

`default_nettype wire

/* verilog/add_regs_pkg.sv */
// Register map of the two-operand adder: data types, offsets, status bits and ID
`default_nettype none

package add_regs_pkg;

  // ------------------------------------------------
  // Widths that carry a meaning
  // ------------------------------------------------

  // One register data word
  typedef logic [31:0] data_word_t;
  // Byte address as seen on the register port
  typedef logic [31:0] reg_addr_t;
  // Word index, address bits 4:2
  typedef logic [2:0]  word_offset_t;

  // ------------------------------------------------
  // Byte offsets of the register map
  // ------------------------------------------------

  // Operands, read and write
  localparam reg_addr_t OFF_OP_A   = 32'h0000_0000;
  localparam reg_addr_t OFF_OP_B   = 32'h0000_0004;
  // Results, read only
  localparam reg_addr_t OFF_SUM    = 32'h0000_0008;
  localparam reg_addr_t OFF_STATUS = 32'h0000_000C;
  localparam reg_addr_t OFF_ID     = 32'h0000_0010;
  // First unmapped byte address
  localparam reg_addr_t ADDR_SPAN  = 32'h0000_0020;

  // Word indices used by the decoders
  localparam word_offset_t WOFF_OP_A   = word_offset_t'(OFF_OP_A >> 2);
  localparam word_offset_t WOFF_OP_B   = word_offset_t'(OFF_OP_B >> 2);
  localparam word_offset_t WOFF_SUM    = word_offset_t'(OFF_SUM >> 2);
  localparam word_offset_t WOFF_STATUS = word_offset_t'(OFF_STATUS >> 2);
  localparam word_offset_t WOFF_ID     = word_offset_t'(OFF_ID >> 2);

  // STATUS bit positions
  localparam int unsigned ST_CARRY_BIT = 0;
  localparam int unsigned ST_OVF_BIT   = 1;

  // Fixed identification word
  localparam data_word_t PERIPH_ID = 32'hADD0_0001;

endpackage

`default_nettype wire

/* verilog/add_response_unit.sv */
// Response unit: adds the operands, serves reads and merges both paths into one response
`timescale 1ns/1ps
`default_nettype none

module add_response_unit (
  input  add_regs_pkg::data_word_t op_a,
  input  add_regs_pkg::data_word_t op_b,
  input  add_bus_pkg::wr_result_t  wr_res,
  input  add_bus_pkg::rd_pending_t rd_pend,
  output add_bus_pkg::reg_rsp_t    rsp
);

  import add_regs_pkg::*;
  import add_bus_pkg::*;

  logic [32:0] sum_ext;
  data_word_t  sum;
  logic        carry;
  logic        overflow;
  data_word_t  status_word;
  data_word_t  rd_word;

  // ------------------------------------------------
  // Adder
  // ------------------------------------------------

  // One extra bit keeps the unsigned carry
  assign sum_ext = {1'b0, op_a} + {1'b0, op_b};
  assign sum     = sum_ext[31:0];
  assign carry   = sum_ext[32];

  // Same operand signs but a different result sign
  assign overflow = (op_a[31] == op_b[31]) && (sum[31] != op_a[31]);

  always_comb begin
    status_word              = '0;
    status_word[ST_CARRY_BIT] = carry;
    status_word[ST_OVF_BIT]   = overflow;
  end

  // ------------------------------------------------
  // Read data select
  // ------------------------------------------------

  // Operands already include a write from the cycle before
  always_comb begin
    unique case (rd_pend.word_offset)
      WOFF_OP_A:   rd_word = op_a;
      WOFF_OP_B:   rd_word = op_b;
      WOFF_SUM:    rd_word = sum;
      WOFF_STATUS: rd_word = status_word;
      WOFF_ID:     rd_word = PERIPH_ID;
      // Words 5..7 are in span but empty
      default:     rd_word = '0;
    endcase
  end

  // ------------------------------------------------
  // Response merge
  // ------------------------------------------------

  // A write and a read are never pending together,
  // so both flags can simply be ORed
  always_comb begin
    rsp.valid = wr_res.done || rd_pend.pending;
    rsp.error = (wr_res.done && wr_res.error) || (rd_pend.pending && rd_pend.error);
    // Data only for a clean read
    if (rd_pend.pending && !rd_pend.error) begin
      rsp.rdata = rd_word;
    end else begin
      rsp.rdata = '0;
    end
  end

endmodule

`default_nettype wire

/* verilog/add_two_number_wrapper.sv */
// Top level of the adder peripheral on the coprocessor register port
`timescale 1ns/1ps
`default_nettype none

module add_two_number_wrapper (
  // Clock and reset
  input  logic                  clk_i,
  input  logic                  rst_n,
  // Register request from the bus master
  input  add_bus_pkg::reg_req_t req,
  // Response, one cycle after each request
  output add_bus_pkg::reg_rsp_t rsp
);

  import add_regs_pkg::*;
  import add_bus_pkg::*;

  // ------------------------------------------------
  // Internal connections
  // ------------------------------------------------

  // Operand values held by the bank
  data_word_t  op_a;
  data_word_t  op_b;
  // Registered write outcome
  wr_result_t  wr_res;
  // Registered read entry
  rd_pending_t rd_pend;

  // Write path
  add_operand_bank u_operand_bank (
    .clk_i  (clk_i),
    .rst_n  (rst_n),
    .req    (req),
    .op_a   (op_a),
    .op_b   (op_b),
    .wr_res (wr_res)
  );

  // Read path, sees the same request in the same cycle
  add_read_tracker u_read_tracker (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .req     (req),
    .rd_pend (rd_pend)
  );

  // Sum, status and the merged response
  add_response_unit u_response_unit (
    .op_a    (op_a),
    .op_b    (op_b),
    .wr_res  (wr_res),
    .rd_pend (rd_pend),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire
